// ==== verilog/cpu_params.svh ====
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// datapath and instruction word width
`define DATA_W 16

// register file size, 0..7 general plus specials
`define REG_CNT 16

// special register numbers
`define SP_REG 4'd8
`define T_REG 4'd9
`define IH_REG 4'd10
`define ZERO_REG 4'd15 // reads zero, writes dropped

`endif

// ==== verilog/isaPkg.sv ====
package isaPkg;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rx;
        logic [7:0] imm;
    } immFmtT;

    typedef struct packed {
        logic [4:0] opcode;
        logic [2:0] rx;
        logic [2:0] ry;
        logic [4:0] func; // rz, shift amount or sub-op
    } regFmtT;

    // one instruction word, seen either as imm or reg format
    typedef union packed {
        immFmtT immView;
        regFmtT regView;
    } instrWord;

    //////////////////////////////
    // major opcodes
    localparam logic [4:0] OP_SHIFT  = 5'b00110; // SLL, SRA
    localparam logic [4:0] OP_ADDIU3 = 5'b01000;
    localparam logic [4:0] OP_ADDIU  = 5'b01001;
    localparam logic [4:0] OP_SLTUI  = 5'b01011;
    localparam logic [4:0] OP_SPEC   = 5'b01100; // ADDSP, MTSP, BTEQZ
    localparam logic [4:0] OP_LI     = 5'b01101;
    localparam logic [4:0] OP_MOVE   = 5'b01111;
    localparam logic [4:0] OP_RRR    = 5'b11100; // ADDU, SUBU
    localparam logic [4:0] OP_ALU    = 5'b11101;
    localparam logic [4:0] OP_IH     = 5'b11110; // MFIH, MTIH

    // sub-op fields
    localparam logic [2:0] SUB_ADDSP = 3'b011;
    localparam logic [2:0] SUB_MTSP  = 3'b100;
    localparam logic [1:0] SH_SLL    = 2'b00;
    localparam logic [1:0] SH_SRA    = 2'b11;
    localparam logic [1:0] RR_ADDU   = 2'b01;
    localparam logic [1:0] RR_SUBU   = 2'b11;
    localparam logic [4:0] FN_SLT    = 5'b00010;
    localparam logic [4:0] FN_CMP    = 5'b01010;
    localparam logic [4:0] FN_NEG    = 5'b01011;
    localparam logic [4:0] FN_AND    = 5'b01100;
    localparam logic [4:0] FN_OR     = 5'b01101;
    localparam logic [4:0] FN_NOT    = 5'b01111;
    localparam logic [4:0] FN_MFIH   = 5'b00000;
    localparam logic [4:0] FN_MTIH   = 5'b00001;

endpackage

// ==== verilog/pipePkg.sv ====
`include "cpu_params.svh"

package pipePkg;

    typedef enum logic [3:0] {
        ALU_ADD = 4'd0,
        ALU_SUB = 4'd1,
        ALU_AND = 4'd2,
        ALU_OR  = 4'd3,
        ALU_NEG = 4'd4,
        ALU_NOT = 4'd5,
        ALU_SLL = 4'd6,
        ALU_SRA = 4'd8,
        ALU_SLT = 4'd9,
        ALU_CMP = 4'd10
    } aluOpT;

    typedef enum logic [1:0] {
        B_REG  = 2'b00,
        B_IMM  = 2'b01,
        B_ZERO = 2'b10
    } bSelT;

    typedef struct packed {
        aluOpT              aluOp;
        bSelT               bSel;
        logic [3:0]         readReg1;
        logic [3:0]         readReg2;
        logic [3:0]         writeReg; // ZERO_REG when nothing is written
        logic [`DATA_W-1:0] imm;
    } decodedCtrl;

    typedef struct packed {
        logic               valid;
        logic [3:0]         regNum;
        logic [`DATA_W-1:0] data;
    } wbBus;

endpackage

// ==== verilog/instrDecoder.sv ====
`include "cpu_params.svh"

module instrDecoder import isaPkg::*, pipePkg::*; (
    input  instrWord   instr,
    output decodedCtrl ctrl
);

    logic [4:0]         op;
    logic [2:0]         rx;
    logic [2:0]         ry;
    logic [4:0]         fn;
    logic [7:0]         imm8;
    logic [3:0]         shAmt;
    logic [`DATA_W-1:0] sext8;
    logic [`DATA_W-1:0] zext8;
    logic [`DATA_W-1:0] sext4;

    // both views of the same word
    assign op   = instr.immView.opcode;
    assign rx   = instr.immView.rx;
    assign imm8 = instr.immView.imm;
    assign ry   = instr.regView.ry;
    assign fn   = instr.regView.func;

    assign sext8 = {{(`DATA_W-8){imm8[7]}}, imm8};
    assign zext8 = {{(`DATA_W-8){1'b0}}, imm8};
    assign sext4 = {{(`DATA_W-4){fn[3]}}, fn[3:0]};
    assign shAmt = (fn[4:2] == 3'd0) ? 4'd8 : {1'b0, fn[4:2]}; // 0 encodes 8

    always_comb begin
        // default is a non-writing op: loads, stores, branches, jumps, unknown
        ctrl.aluOp    = ALU_ADD;
        ctrl.bSel     = B_ZERO;
        ctrl.readReg1 = `ZERO_REG;
        ctrl.readReg2 = `ZERO_REG;
        ctrl.writeReg = `ZERO_REG;
        ctrl.imm      = '0;

        case (op)
            OP_ADDIU: begin
                ctrl.readReg1 = {1'b0, rx};
                ctrl.bSel     = B_IMM;
                ctrl.imm      = sext8;
                ctrl.writeReg = {1'b0, rx};
            end
            OP_ADDIU3: begin
                if (!fn[4]) begin
                    ctrl.readReg1 = {1'b0, rx};
                    ctrl.bSel     = B_IMM;
                    ctrl.imm      = sext4;
                    ctrl.writeReg = {1'b0, ry};
                end
            end
            OP_SPEC: begin
                if (rx == SUB_ADDSP) begin
                    ctrl.readReg1 = `SP_REG;
                    ctrl.bSel     = B_IMM;
                    ctrl.imm      = sext8;
                    ctrl.writeReg = `SP_REG;
                end else if (rx == SUB_MTSP) begin
                    ctrl.readReg1 = {1'b0, ry}; // SP = ry + 0
                    ctrl.writeReg = `SP_REG;
                end
            end
            OP_SLTUI: begin
                ctrl.aluOp    = ALU_SLT;
                ctrl.readReg1 = {1'b0, rx};
                ctrl.bSel     = B_IMM;
                ctrl.imm      = zext8;
                ctrl.writeReg = `T_REG;
            end
            OP_LI: begin
                ctrl.bSel     = B_IMM; // zero + imm
                ctrl.imm      = zext8;
                ctrl.writeReg = {1'b0, rx};
            end
            OP_MOVE: begin
                if (fn == 5'd0) begin
                    ctrl.readReg1 = {1'b0, ry};
                    ctrl.writeReg = {1'b0, rx};
                end
            end
            OP_SHIFT: begin
                if (fn[1:0] == SH_SLL || fn[1:0] == SH_SRA) begin
                    ctrl.aluOp    = (fn[1:0] == SH_SLL) ? ALU_SLL : ALU_SRA;
                    ctrl.readReg1 = {1'b0, ry};
                    ctrl.bSel     = B_IMM;
                    ctrl.imm      = {{(`DATA_W-4){1'b0}}, shAmt};
                    ctrl.writeReg = {1'b0, rx};
                end
            end
            OP_RRR: begin
                if (fn[1:0] == RR_ADDU || fn[1:0] == RR_SUBU) begin
                    ctrl.aluOp    = (fn[1:0] == RR_ADDU) ? ALU_ADD : ALU_SUB;
                    ctrl.readReg1 = {1'b0, rx};
                    ctrl.readReg2 = {1'b0, ry};
                    ctrl.bSel     = B_REG;
                    ctrl.writeReg = {1'b0, fn[4:2]}; // rz
                end
            end
            OP_ALU: begin
                ctrl.readReg1 = {1'b0, rx};
                ctrl.readReg2 = {1'b0, ry};
                ctrl.bSel     = B_REG;
                ctrl.writeReg = {1'b0, rx};
                case (fn)
                    FN_AND: ctrl.aluOp = ALU_AND;
                    FN_OR:  ctrl.aluOp = ALU_OR;
                    FN_NEG: ctrl.aluOp = ALU_NEG;
                    FN_NOT: ctrl.aluOp = ALU_NOT;
                    FN_SLT: begin
                        ctrl.aluOp    = ALU_SLT;
                        ctrl.writeReg = `T_REG;
                    end
                    FN_CMP: begin
                        ctrl.aluOp    = ALU_CMP;
                        ctrl.writeReg = `T_REG;
                    end
                    default: ctrl.writeReg = `ZERO_REG; // JR, JALR, MFPC
                endcase
            end
            OP_IH: begin
                if (fn == FN_MFIH) begin
                    ctrl.readReg1 = `IH_REG;
                    ctrl.writeReg = {1'b0, rx};
                end else if (fn == FN_MTIH) begin
                    ctrl.readReg1 = {1'b0, rx};
                    ctrl.writeReg = `IH_REG;
                end
            end
            default: ;
        endcase
    end

endmodule

// ==== verilog/regFile.sv ====
`include "cpu_params.svh"

module regFile import pipePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  wbBus               wb,
    input  logic [3:0]         readReg1,
    input  logic [3:0]         readReg2,
    output logic [`DATA_W-1:0] readData1,
    output logic [`DATA_W-1:0] readData2
);

    logic [`DATA_W-1:0] regs [`REG_CNT];

    //////////////////////////////
    // write port
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < `REG_CNT; i++) begin
                regs[i] <= '0;
            end
        end else if (wb.valid && wb.regNum != `ZERO_REG) begin
            regs[wb.regNum] <= wb.data;
        end
    end

    //////////////////////////////
    // read ports, no write bypass here
    always_comb begin
        if (readReg1 == `ZERO_REG) readData1 = '0;
        else                       readData1 = regs[readReg1];

        if (readReg2 == `ZERO_REG) readData2 = '0;
        else                       readData2 = regs[readReg2];
    end

endmodule

// ==== verilog/aluUnit.sv ====
`include "cpu_params.svh"

module aluUnit import pipePkg::*; (
    input  aluOpT              op,
    input  logic [`DATA_W-1:0] a,
    input  logic [`DATA_W-1:0] b,
    output logic [`DATA_W-1:0] y
);

    localparam logic [`DATA_W-1:0] ONE = 1;

    logic signedLess;

    assign signedLess = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            ALU_ADD: y = a + b;
            ALU_SUB: y = a - b;
            ALU_AND: y = a & b;
            ALU_OR:  y = a | b;
            ALU_NEG: y = '0 - b; // only b matters
            ALU_NOT: y = ~b;
            ALU_SLL: y = a << b;
            ALU_SRA: y = $signed(a) >>> b;
            ALU_SLT: y = signedLess ? ONE : '0;

            // T = 0 on equal
            ALU_CMP: y = (a == b) ? '0 : ONE;
            default: y = '0;
        endcase
    end

endmodule

// ==== verilog/execStage.sv ====
`include "cpu_params.svh"

module execStage import pipePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               instrValid,
    input  decodedCtrl         ctrl,
    input  logic [`DATA_W-1:0] readData1,
    input  logic [`DATA_W-1:0] readData2,
    output wbBus               wb
);

    // execute register
    logic               exValid;
    aluOpT              exOp;
    logic [3:0]         exWriteReg;
    logic [`DATA_W-1:0] exA;
    logic [`DATA_W-1:0] exB;

    logic [`DATA_W-1:0] aluY;
    logic [`DATA_W-1:0] opA;
    logic [`DATA_W-1:0] regB;
    logic [`DATA_W-1:0] opB;

    // newest in-flight write wins
    function automatic logic [`DATA_W-1:0] fwd(input logic [3:0] r,
                                              input logic [`DATA_W-1:0] rd);
        if (exValid && exWriteReg == r) return aluY;
        if (wb.valid && wb.regNum == r) return wb.data;
        return rd;
    endfunction

    always_comb begin
        opA  = fwd(ctrl.readReg1, readData1);
        regB = fwd(ctrl.readReg2, readData2);
        case (ctrl.bSel)
            B_REG:   opB = regB;
            B_IMM:   opB = ctrl.imm;
            default: opB = '0;
        endcase
    end

    aluUnit aluUnit_i (.op(exOp), .a(exA), .b(exB), .y(aluY));

    //////////////////////////////
    // execute and writeback registers
    always_ff @(posedge clk) begin
        exOp       <= ctrl.aluOp;
        exWriteReg <= ctrl.writeReg;
        exA        <= opA;
        exB        <= opB;
        wb.regNum  <= exWriteReg;
        wb.data    <= aluY;
        if (rst) begin
            exValid  <= 1'b0;
            wb.valid <= 1'b0;
        end else begin
            exValid  <= instrValid && (ctrl.writeReg != `ZERO_REG); // reg 15 never writes back
            wb.valid <= exValid;
        end
    end

endmodule

// ==== verilog/decodeCore.sv ====
`include "cpu_params.svh"

module decodeCore import isaPkg::*, pipePkg::*; (
    input  logic               clk,
    input  logic               rst,
    input  logic               instrValid,
    input  instrWord           instr,
    output logic               wbValid,
    output logic [3:0]         wbReg,
    output logic [`DATA_W-1:0] wbData
);

    decodedCtrl         ctrl;
    wbBus               wb;
    logic [`DATA_W-1:0] readData1;
    logic [`DATA_W-1:0] readData2;

    instrDecoder instrDecoder_i (.instr(instr), .ctrl(ctrl));

    regFile regFile_i (
        .clk(clk),
        .rst(rst),
        .wb(wb),
        .readReg1(ctrl.readReg1),
        .readReg2(ctrl.readReg2),
        .readData1(readData1),
        .readData2(readData2)
    );

    execStage execStage_i (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .ctrl(ctrl),
        .readData1(readData1),
        .readData2(readData2),
        .wb(wb)
    );

    // writeback is also the observation port
    assign wbValid = wb.valid;
    assign wbReg   = wb.regNum;
    assign wbData  = wb.data;

endmodule

// ==== test/decodeCore_chk.sv ====
`include "cpu_params.svh"

module decodeCore_chk import pipePkg::*; (
    input logic       clk,
    input logic       rst,
    input logic       instrValid,
    input decodedCtrl ctrl,
    input logic       wbValid,
    input logic [3:0] wbReg
);

    timeunit 1ns;
    timeprecision 100ps;

    int   assertFails = 0;
    logic writes;

    assign writes = instrValid && ctrl.writeReg != `ZERO_REG; // issue that must write back

    wbQuietInReset: assert property (@(posedge clk) rst |=> !wbValid)
        else begin
            assertFails++;
            $error("wbValid high after a reset edge");
        end

    // register 15 never shows up as a destination
    noZeroRegWb: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> wbReg != `ZERO_REG)
        else begin
            assertFails++;
            $error("writeback to register 15");
        end

    wbAfterIssue: assert property (@(posedge clk) disable iff (rst) writes |-> ##2 wbValid)
        else begin
            assertFails++;
            $error("writing instruction gave no writeback");
        end

    noSpuriousWb: assert property (@(posedge clk) disable iff (rst)
        wbValid |-> $past(writes, 2))
        else begin
            assertFails++;
            $error("writeback without a writing instruction");
        end

endmodule

bind decodeCore decodeCore_chk checks (
    .clk(clk),
    .rst(rst),
    .instrValid(instrValid),
    .ctrl(ctrl),
    .wbValid(wbValid),
    .wbReg(wbReg)
);

// ==== test/decodeCore_tb.sv ====
`include "cpu_params.svh"

module decodeCore_tb import isaPkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int NUM_INSTR   = 600;
    localparam int CYCLE_LIMIT = 4 * NUM_INSTR + 100;

    // ADDU r1 = r2 + r3 straight after reset
    localparam logic [15:0] FIRST_INSTR = {OP_RRR, 3'd2, 3'd3, 3'd1, RR_ADDU};

    typedef struct packed {
        logic [3:0]         regNum;
        logic [`DATA_W-1:0] data;
        logic [31:0]        issued; // cycle count when driven
    } expectT;

    logic               clk;
    logic               rst;
    logic               instrValid;
    instrWord           instr;
    logic               wbValid;
    logic [3:0]         wbReg;
    logic [`DATA_W-1:0] wbData;

    logic [`DATA_W-1:0] model [`REG_CNT];
    expectT             pending [$];
    logic [31:0]        rngState = 32'd29277;
    int                 cycleCnt = 0;
    int                 valueErrs = 0;
    int                 otherErrs = 0;

    decodeCore decodeCore_i (
        .clk(clk),
        .rst(rst),
        .instrValid(instrValid),
        .instr(instr),
        .wbValid(wbValid),
        .wbReg(wbReg),
        .wbData(wbData)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCnt <= cycleCnt + 1;
        if (cycleCnt >= CYCLE_LIMIT) begin
            $display("timeout: run still busy after %0d cycles", CYCLE_LIMIT);
            $display("RESULT: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] nextRand();
        rngState = rngState ^ (rngState << 13);
        rngState = rngState ^ (rngState >> 17);
        rngState = rngState ^ (rngState << 5);
        return rngState;
    endfunction

    task automatic checkVal(input string name, input logic [31:0] got, input logic [31:0] want);
        if (got !== want) begin
            $display("error at %0d ns: %s is %0h, expected %0h", $time, name, got, want);
            valueErrs++;
        end
    endtask

    //////////////////////////////
    // stimulus

    function automatic logic [15:0] randInstr();
        logic [31:0]      r;
        logic [2:0]       rx;
        logic [2:0]       ry;
        logic [2:0]       rz;
        logic [7:0]       imm;
        logic [2:0]       sel;
        logic [5:0][4:0]  aluFns;
        logic [3:0][4:0]  quietOps; // LW, SW, B, BEQZ
        r        = nextRand();
        rx       = r[2:0];
        ry       = r[5:3];
        rz       = r[8:6];   // also the shift amount
        imm      = r[16:9];
        sel      = 3'(r % 6);
        aluFns   = {FN_AND, FN_OR, FN_NEG, FN_NOT, FN_SLT, FN_CMP};
        quietOps = {5'b10011, 5'b11011, 5'b00010, 5'b00100};
        case (nextRand() % 16)
            0:  return {OP_ADDIU, rx, imm};
            1:  return {OP_ADDIU3, rx, ry, 1'b0, imm[3:0]};
            2:  return {OP_LI, rx, imm};
            3:  return {OP_SLTUI, rx, imm};
            4:  return {OP_SPEC, SUB_ADDSP, imm};
            5:  return {OP_SPEC, SUB_MTSP, ry, 5'd0};
            6:  return {OP_MOVE, rx, ry, 5'd0};
            7:  return {OP_SHIFT, rx, ry, rz, SH_SLL};
            8:  return {OP_SHIFT, rx, ry, rz, SH_SRA};
            9:  return {OP_RRR, rx, ry, rz, RR_ADDU};
            10: return {OP_RRR, rx, ry, rz, RR_SUBU};
            11: return {OP_ALU, rx, ry, aluFns[sel]};
            12: return {OP_IH, rx, 3'd0, FN_MFIH};
            13: return {OP_IH, rx, 3'd0, FN_MTIH};
            14: return r[19] ? {OP_ALU, rx, 3'd0, 5'd0} : {OP_SPEC, 3'b000, imm}; // JR, BTEQZ
            default: return {quietOps[r[18:17]], rx, imm};
        endcase
    endfunction

    // runs one instruction on the model registers and returns 1 on a register write
    function automatic bit refExec(input logic [15:0] ins, output logic [3:0] dst,
                                   output logic [`DATA_W-1:0] val);
        logic [2:0]         rx;
        logic [4:0]         fn;
        logic [`DATA_W-1:0] a;
        logic [`DATA_W-1:0] b;
        logic [`DATA_W-1:0] imm8s;
        logic [`DATA_W-1:0] imm8z;
        logic [3:0]         amt;
        rx    = ins[10:8];
        fn    = ins[4:0];
        a     = model[rx];
        b     = model[ins[7:5]];
        imm8s = {{8{ins[7]}}, ins[7:0]};
        imm8z = {8'd0, ins[7:0]};
        amt   = (fn[4:2] == 3'd0) ? 4'd8 : {1'b0, fn[4:2]}; // 0 shifts by 8
        dst   = `ZERO_REG;
        val   = '0;
        case (ins[15:11])
            OP_ADDIU:  {dst, val} = {{1'b0, rx}, a + imm8s};
            OP_ADDIU3: if (!fn[4]) {dst, val} = {{1'b0, ins[7:5]}, a + {{12{fn[3]}}, fn[3:0]}};
            OP_LI:     {dst, val} = {{1'b0, rx}, imm8z};
            OP_SLTUI:  {dst, val} = {`T_REG, 16'($signed(a) < $signed(imm8z))};
            OP_MOVE:   if (fn == 5'd0) {dst, val} = {{1'b0, rx}, b};
            OP_SPEC: begin
                if (rx == SUB_ADDSP) {dst, val} = {`SP_REG, model[`SP_REG] + imm8s};
                else if (rx == SUB_MTSP) {dst, val} = {`SP_REG, b};
            end
            OP_SHIFT: begin
                if (fn[1:0] == SH_SLL) {dst, val} = {{1'b0, rx}, b << amt};
                else if (fn[1:0] == SH_SRA) {dst, val} = {{1'b0, rx}, $signed(b) >>> amt};
            end
            OP_RRR: begin
                if (fn[1:0] == RR_ADDU) {dst, val} = {{1'b0, fn[4:2]}, a + b};
                else if (fn[1:0] == RR_SUBU) {dst, val} = {{1'b0, fn[4:2]}, a - b};
            end
            OP_ALU: begin
                case (fn)
                    FN_AND:  {dst, val} = {{1'b0, rx}, a & b};
                    FN_OR:   {dst, val} = {{1'b0, rx}, a | b};
                    FN_NEG:  {dst, val} = {{1'b0, rx}, 16'd0 - b};
                    FN_NOT:  {dst, val} = {{1'b0, rx}, ~b};
                    FN_SLT:  {dst, val} = {`T_REG, 16'($signed(a) < $signed(b))};
                    FN_CMP:  {dst, val} = {`T_REG, 16'(a != b)};
                    default: ;
                endcase
            end
            OP_IH: begin
                if (fn == FN_MFIH) {dst, val} = {{1'b0, rx}, model[`IH_REG]};
                else if (fn == FN_MTIH) {dst, val} = {`IH_REG, a};
            end
            default: ; // loads, stores, branches
        endcase
        if (dst != `ZERO_REG) model[dst] = val;
        return dst != `ZERO_REG;
    endfunction

    initial begin
        logic [15:0]        word;
        logic [3:0]         dst;
        logic [`DATA_W-1:0] val;
        int                 issued;
        int                 chkFails;
        issued     = 0;
        rst        = 1'b1;
        instrValid = 1'b0;
        instr      = '0;
        for (int i = 0; i < `REG_CNT; i++) begin
            model[i] = '0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;
        while (issued < NUM_INSTR) begin
            word = (issued == 0) ? FIRST_INSTR : randInstr();
            if (issued > 0 && nextRand() % 4 == 0) begin
                instrValid = 1'b0; // idle cycle so the word is ignored
                instr      = word;
            end else begin
                instrValid = 1'b1;
                instr      = word;
                if (refExec(word, dst, val)) pending.push_back({dst, val, 32'(cycleCnt)});
                issued++;
            end
            @(negedge clk);
        end
        instrValid = 1'b0;
        while (pending.size() != 0) begin
            @(negedge clk);
        end
        repeat (2) @(negedge clk); // room for a stray writeback
        chkFails = decodeCore_i.checks.assertFails;
        $display("errors: %0d value, %0d other, %0d assertion", valueErrs, otherErrs, chkFails);
        if (valueErrs + otherErrs + chkFails == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    //////////////////////////////
    // compare writebacks in order

    always @(negedge clk) begin
        expectT want;
        if (!rst && wbValid) begin
            if (pending.size() == 0) begin
                $display("writeback to register %0d at %0d ns with nothing outstanding",
                         wbReg, $time);
                otherErrs++;
            end else begin
                want = pending.pop_front();
                checkVal("wbReg", 32'(wbReg), 32'(want.regNum));
                checkVal("wbData", 32'(wbData), 32'(want.data));
                checkVal("wbCycle", cycleCnt, want.issued + 2); // fixed latency
            end
        end
    end

endmodule

// ==== project.f ====
+incdir+verilog
verilog/isaPkg.sv
verilog/pipePkg.sv
verilog/instrDecoder.sv
verilog/regFile.sv
verilog/aluUnit.sv
verilog/execStage.sv
verilog/decodeCore.sv
test/decodeCore_chk.sv
test/decodeCore_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
FLAGS     := --binary --timing --assert --timescale 1ns/100ps
TOP       := decodeCore_tb
FILELIST  := project.f
BUILD     := obj_dir
LOG       := sim.log
SIM_ARGS  := +verilator+error+limit+100

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) $(SIM_ARGS) | tee $(LOG)
	@grep -q "^RESULT: PASS$$" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
